/* filelist.f */
+incdir+.
lsu_pkg.sv
lsu_iq_entry.sv
lsu_iq.sv
lsu_agu.sv
lsu_wdata_fmt.sv
lsu_dmem.sv
lsu_top.sv
tb_lsu_top.sv

/* lsu_agu.sv */
`timescale 1ns/1ps

module lsu_agu (
    input  lsu_pkg::issue_t issue_i,
    output lsu_pkg::agu_t   agu_o
);

    import lsu_pkg::*;

    word_t offset_sext;
    word_t addr;

    assign offset_sext = {{20{issue_i.op.offset[11]}}, issue_i.op.offset};
    assign addr        = issue_i.base + offset_sext;

    // low address bits must be zero for the access size
    always_comb begin
        agu_o.addr = addr;
        case (issue_i.op.msize)
            MSIZE_HALF: begin
                agu_o.misaligned = addr[0];
            end
            MSIZE_WORD: begin
                agu_o.misaligned = |addr[1:0];
            end
            default: begin
                agu_o.misaligned = 1'b0;
            end
        endcase
    end

endmodule

/* lsu_dmem.sv */
`timescale 1ns/1ps
`include "lsu_macros.svh"

module lsu_dmem #(
    parameter int MEM_WORDS = `LSU_MEM_WORDS
) (
    input  logic                    clk,
    input  logic                    rst_i,
    input  logic                    flush_i,

    input  logic                    issue_valid_i,
    input  lsu_pkg::lsu_op_t        op_i,
    input  lsu_pkg::agu_t           agu_i,
    input  lsu_pkg::word_t          wdata_i,

    output lsu_pkg::lsu_result_t    result_o
);

    import lsu_pkg::*;

    localparam int IDX_W = $clog2(MEM_WORDS);

    mem_word_u          mem_q [MEM_WORDS];
    logic [IDX_W-1:0]   idx;
    logic               do_access;
    logic [3:0]         strb;
    mem_word_u          rd_word;
    logic [7:0]         lane_b;
    logic [15:0]        lane_h;
    word_t              load_data;

    // a flush also kills the operation leaving the issue register
    assign do_access = issue_valid_i & ~flush_i;
    assign idx       = agu_i.addr[IDX_W+1:2];
    assign rd_word   = mem_q[idx];

    // ------------------------------------------------------------------------
    // store path
    // ------------------------------------------------------------------------
    always_comb begin
        case (op_i.msize)
            MSIZE_BYTE: strb = 4'b0001 << agu_i.addr[1:0];
            MSIZE_HALF: strb = agu_i.addr[1] ? 4'b1100 : 4'b0011;
            default:    strb = 4'b1111;
        endcase
    end

    always_ff @(posedge clk) begin
        if (do_access && op_i.is_store && !agu_i.misaligned) begin
            for (int b = 0; b < 4; b++) begin
                if (strb[b]) begin
                    mem_q[idx].b[b] <= wdata_i[8*b +: 8];
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // load path
    // ------------------------------------------------------------------------
    assign lane_b = rd_word.b[agu_i.addr[1:0]];
    assign lane_h = rd_word.h[agu_i.addr[1]];

    always_comb begin
        case (op_i.msize)
            MSIZE_BYTE: load_data = {{24{op_i.msigned & lane_b[7]}}, lane_b};
            MSIZE_HALF: load_data = {{16{op_i.msigned & lane_h[15]}}, lane_h};
            default:    load_data = rd_word;
        endcase
    end

    logic       res_valid_q;
    rob_id_t    res_id_q;
    word_t      res_data_q;
    logic       res_ale_q;

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            res_valid_q <= 1'b0;
        end else begin
            res_valid_q <= do_access & ~op_i.is_store;
        end
    end

    // misaligned load reports ale with zero data
    always_ff @(posedge clk) begin
        res_id_q   <= op_i.wreg_id;
        res_data_q <= agu_i.misaligned ? '0 : load_data;
        res_ale_q  <= agu_i.misaligned;
    end

    always_comb begin
        result_o.valid   = res_valid_q;
        result_o.wreg_id = res_id_q;
        result_o.data    = res_data_q;
        result_o.ale     = res_ale_q;
    end

endmodule

/* lsu_iq.sv */
`timescale 1ns/1ps
`include "lsu_macros.svh"

module lsu_iq #(
    parameter int IQ_SIZE   = `LSU_IQ_SIZE,
    parameter int CDB_COUNT = `LSU_CDB_COUNT
) (
    input  logic                            clk,
    input  logic                            rst_i,
    input  logic                            flush_i,

    input  lsu_pkg::dispatch_t [1:0]        disp_i,
    // queue can take two more operations
    output logic                            entry_ready_o,

    input  lsu_pkg::cdb_t [CDB_COUNT-1:0]   cdb_i,

    output lsu_pkg::issue_t                 issue_o
);

    import lsu_pkg::*;

    localparam int PTR_W = $clog2(IQ_SIZE);
    localparam int CNT_W = $clog2(IQ_SIZE + 1);

    // ------------------------------------------------------------------------
    // pointers and free count
    // ------------------------------------------------------------------------
    logic [PTR_W-1:0]   head_q, tail_q, tail_p1;
    logic [CNT_W-1:0]   free_q, free_d;
    logic [1:0]         n_acc;
    logic               issue_fire;

    logic [IQ_SIZE-1:0]         entry_ready;
    logic [IQ_SIZE-1:0]         entry_init;
    logic [IQ_SIZE-1:0]         entry_select;
    dispatch_t [IQ_SIZE-1:0]    entry_disp;
    lsu_op_t [IQ_SIZE-1:0]      entry_op;
    word_t [IQ_SIZE-1:0][1:0]   entry_data;

    // dispatch is only taken while the queue advertised room
    assign n_acc      = entry_ready_o ? (2'(disp_i[0].valid) + 2'(disp_i[1].valid)) : 2'd0;
    assign issue_fire = entry_ready[head_q];
    assign tail_p1    = tail_q + PTR_W'(1);
    assign free_d     = free_q - CNT_W'(n_acc) + CNT_W'(issue_fire);

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            head_q        <= '0;
            tail_q        <= '0;
            free_q        <= CNT_W'(IQ_SIZE);
            entry_ready_o <= 1'b1;
        end else begin
            head_q        <= head_q + PTR_W'(issue_fire);
            tail_q        <= tail_q + PTR_W'(n_acc);
            free_q        <= free_d;
            entry_ready_o <= (free_d >= CNT_W'(2));
        end
    end

    // ------------------------------------------------------------------------
    // slot compaction, older slot always lands at the tail
    // ------------------------------------------------------------------------
    always_comb begin
        entry_init = '0;
        entry_disp = '0;
        if (entry_ready_o) begin
            if (disp_i[0].valid) begin
                entry_init[tail_q] = 1'b1;
                entry_disp[tail_q] = disp_i[0];
                if (disp_i[1].valid) begin
                    entry_init[tail_p1] = 1'b1;
                    entry_disp[tail_p1] = disp_i[1];
                end
            end else if (disp_i[1].valid) begin
                entry_init[tail_q] = 1'b1;
                entry_disp[tail_q] = disp_i[1];
            end
        end
    end

    // in-order issue, only the head may leave
    always_comb begin
        entry_select         = '0;
        entry_select[head_q] = issue_fire;
    end

    for (genvar i = 0; i < IQ_SIZE; i++) begin : g_entry
        lsu_iq_entry #(
            .CDB_COUNT(CDB_COUNT)
        ) entry_i (
            .clk,
            .rst_i,
            .flush_i,
            .init_i   (entry_init[i]),
            .disp_i   (entry_disp[i]),
            .select_i (entry_select[i]),
            .cdb_i,
            .ready_o  (entry_ready[i]),
            .op_o     (entry_op[i]),
            .data_o   (entry_data[i])
        );
    end

    // ------------------------------------------------------------------------
    // issue register
    // ------------------------------------------------------------------------
    logic       issue_valid_q;
    lsu_op_t    issue_op_q;
    word_t      issue_base_q;
    word_t      issue_sdata_q;

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            issue_valid_q <= 1'b0;
        end else begin
            issue_valid_q <= issue_fire;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_fire) begin
            issue_op_q    <= entry_op[head_q];
            issue_base_q  <= entry_data[head_q][1];
            issue_sdata_q <= entry_data[head_q][0];
        end
    end

    always_comb begin
        issue_o.valid = issue_valid_q;
        issue_o.op    = issue_op_q;
        issue_o.base  = issue_base_q;
        issue_o.sdata = issue_sdata_q;
    end

endmodule

/* lsu_iq_entry.sv */
`timescale 1ns/1ps
`include "lsu_macros.svh"

module lsu_iq_entry #(
    parameter int CDB_COUNT = `LSU_CDB_COUNT
) (
    input  logic                                clk,
    input  logic                                rst_i,
    input  logic                                flush_i,

    input  logic                                init_i,
    input  lsu_pkg::dispatch_t                  disp_i,
    input  logic                                select_i,

    input  lsu_pkg::cdb_t [CDB_COUNT-1:0]       cdb_i,

    output logic                                ready_o,
    output lsu_pkg::lsu_op_t                    op_o,
    output lsu_pkg::word_t [1:0]                data_o
);

    import lsu_pkg::*;

    logic           busy_q;
    logic [1:0]     have_q;
    lsu_op_t        op_q;
    rob_id_t [1:0]  id_q;
    word_t [1:0]    data_q;

    // tags to snoop for, taken from the slot being loaded in the init cycle
    rob_id_t [1:0]  want_id;
    logic [1:0]     hit;
    word_t [1:0]    hit_data;

    assign want_id = init_i ? disp_i.src_id : id_q;

    always_comb begin
        for (int k = 0; k < 2; k++) begin
            hit[k]      = 1'b0;
            hit_data[k] = '0;
            for (int p = 0; p < CDB_COUNT; p++) begin
                if (cdb_i[p].valid && cdb_i[p].id == want_id[k]) begin
                    hit[k]      = 1'b1;
                    hit_data[k] = cdb_i[p].data;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            busy_q <= 1'b0;
            have_q <= '0;
        end else if (init_i) begin
            busy_q <= 1'b1;
            have_q <= disp_i.src_ready | hit;
        end else if (select_i) begin
            busy_q <= 1'b0;
        end else if (busy_q) begin
            have_q <= have_q | hit;
        end
    end

    // operand capture, an operand already held keeps its value
    always_ff @(posedge clk) begin
        if (init_i) begin
            op_q <= disp_i.op;
            id_q <= disp_i.src_id;
            for (int k = 0; k < 2; k++) begin
                data_q[k] <= disp_i.src_ready[k] ? disp_i.src_data[k] : hit_data[k];
            end
        end else begin
            for (int k = 0; k < 2; k++) begin
                if (!have_q[k] && hit[k]) begin
                    data_q[k] <= hit_data[k];
                end
            end
        end
    end

    assign ready_o = busy_q & (&have_q);
    assign op_o    = op_q;
    assign data_o  = data_q;

endmodule

/* lsu_macros.svh */
`ifndef LSU_MACROS_SVH
`define LSU_MACROS_SVH

// ----------------------------------------------------------------------------
// load/store issue side sizing
// ----------------------------------------------------------------------------

// issue queue depth, power of two
`define LSU_IQ_SIZE 4

// result broadcast ports snooped by the queue
`define LSU_CDB_COUNT 2

// scratchpad depth in 32-bit words, power of two
`define LSU_MEM_WORDS 64

// rob tag width
`define LSU_ROB_ID_W 6

`endif

/* lsu_pkg.sv */
`include "lsu_macros.svh"

package lsu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [`LSU_ROB_ID_W-1:0] rob_id_t;

    // access size of a memory operation
    typedef enum logic [1:0] {
        MSIZE_BYTE = 2'd0,
        MSIZE_HALF = 2'd1,
        MSIZE_WORD = 2'd2
    } mem_size_e;

    // decoded memory operation
    typedef struct packed {
        logic      is_store;
        mem_size_e msize;
        logic      msigned;
        logic [11:0] offset;
        rob_id_t   wreg_id;
    } lsu_op_t;

    // one dispatch slot, operand 0 is store data, operand 1 is base
    typedef struct packed {
        logic           valid;
        lsu_op_t        op;
        logic [1:0]     src_ready;
        rob_id_t [1:0]  src_id;
        word_t [1:0]    src_data;
    } dispatch_t;

    // one result broadcast
    typedef struct packed {
        logic    valid;
        rob_id_t id;
        word_t   data;
    } cdb_t;

    typedef struct packed {
        logic    valid;
        lsu_op_t op;
        word_t   base;
        word_t   sdata;
    } issue_t;

    typedef struct packed {
        word_t addr;
        logic  misaligned;
    } agu_t;

    typedef struct packed {
        logic    valid;
        rob_id_t wreg_id;
        word_t   data;
        logic    ale;
    } lsu_result_t;

    // memory word seen as byte lanes or halfword lanes
    typedef union packed {
        logic [3:0][7:0]  b;
        logic [1:0][15:0] h;
    } mem_word_u;

endpackage

/* lsu_top.sv */
`timescale 1ns/1ps
`include "lsu_macros.svh"

module lsu_top (
    input  logic                                    clk,
    input  logic                                    rst_i,
    input  logic                                    flush_i,

    input  lsu_pkg::dispatch_t [1:0]                disp_i,
    output logic                                    entry_ready_o,

    input  lsu_pkg::cdb_t [`LSU_CDB_COUNT-1:0]      cdb_i,

    output lsu_pkg::lsu_result_t                    result_o
);

    import lsu_pkg::*;

    issue_t issue;
    agu_t   agu;
    word_t  wdata;

    lsu_iq #(
        .IQ_SIZE   (`LSU_IQ_SIZE),
        .CDB_COUNT (`LSU_CDB_COUNT)
    ) lsu_iq_i (
        .clk,
        .rst_i,
        .flush_i,
        .disp_i,
        .entry_ready_o,
        .cdb_i,
        .issue_o       (issue)
    );

    // address and store data are formed side by side
    lsu_agu lsu_agu_i (
        .issue_i (issue),
        .agu_o   (agu)
    );

    lsu_wdata_fmt lsu_wdata_fmt_i (
        .sdata_i (issue.sdata),
        .msize_i (issue.op.msize),
        .wdata_o (wdata)
    );

    lsu_dmem #(
        .MEM_WORDS (`LSU_MEM_WORDS)
    ) lsu_dmem_i (
        .clk,
        .rst_i,
        .flush_i,
        .issue_valid_i (issue.valid),
        .op_i          (issue.op),
        .agu_i         (agu),
        .wdata_i       (wdata),
        .result_o
    );

endmodule

/* lsu_wdata_fmt.sv */
`timescale 1ns/1ps

module lsu_wdata_fmt (
    input  lsu_pkg::word_t      sdata_i,
    input  lsu_pkg::mem_size_e  msize_i,
    output lsu_pkg::word_t      wdata_o
);

    import lsu_pkg::*;

    // copy the payload into every lane, the strobe picks the real one
    always_comb begin
        case (msize_i)
            MSIZE_BYTE: begin
                wdata_o = {4{sdata_i[7:0]}};
            end
            MSIZE_HALF: begin
                wdata_o = {2{sdata_i[15:0]}};
            end
            default: begin
                wdata_o = sdata_i;
            end
        endcase
    end

endmodule

/* tb_lsu_top.sv */
`timescale 1ns/1ps
`include "lsu_macros.svh"

module tb_lsu_top;

    import lsu_pkg::*;

    // row flags
    localparam logic [5:0] PAIR   = 6'd1;   // goes out together with the next row
    localparam logic [5:0] SLOT1  = 6'd2;
    localparam logic [5:0] SQUASH = 6'd4;   // killed by a flush before it can issue
    localparam logic [5:0] FLUSH  = 6'd8;
    localparam logic [5:0] TIMED  = 6'd16;
    localparam logic [5:0] RDY_LO = 6'd32;

    typedef struct packed {
        logic        is_store;
        mem_size_e   msize;
        logic        msigned;
        logic [11:0] offset;
        word_t       base;
        logic [1:0]  late;      // operand arrives on the cdb
        logic [1:0]  port;      // cdb port per operand
        logic [3:0]  delay;     // cycles after the dispatch cycle
        logic [5:0]  flags;
    } row_t;

    typedef struct packed {
        int      cyc;
        logic    port;
        rob_id_t tag;
        word_t   data;
    } bcast_t;

    logic                       clk;
    logic                       rst;
    logic                       flush;
    dispatch_t [1:0]            disp;
    logic                       entry_ready;
    cdb_t [`LSU_CDB_COUNT-1:0]  cdb;
    lsu_result_t                result;

    row_t           tbl [$];
    bcast_t         sched [$];
    bcast_t         held [$];
    lsu_result_t    exp_q [$];
    word_t          ref_mem [`LSU_MEM_WORDS];
    word_t          rng;
    rob_id_t        tag_ctr;
    rob_id_t        wid;
    int             cyc;
    logic           probe_on;
    rob_id_t        probe_id;
    int             probe_cyc;

    lsu_top lsu_top_i (
        .clk           (clk),
        .rst_i         (rst),
        .flush_i       (flush),
        .disp_i        (disp),
        .entry_ready_o (entry_ready),
        .cdb_i         (cdb),
        .result_o      (result)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ------------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------------
    function automatic word_t xorshift32(input word_t x);
        word_t y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic word_t next_word();
        rng = xorshift32(rng);
        return rng;
    endfunction

    function automatic logic has(input row_t r, input logic [5:0] f);
        return |(r.flags & f);
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_result(input lsu_result_t got, input lsu_result_t exp);
        if (got !== exp) begin
            stop_run($sformatf({"mismatch at time %0t: result id %0d data %h ale %0b,",
                " expected id %0d data %h ale %0b"}, $time, got.wreg_id, got.data,
                got.ale, exp.wreg_id, exp.data, exp.ale));
        end
    endtask

    task automatic check_ready(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            stop_run($sformatf("mismatch at time %0t: entry_ready_o %s is %b, expected %b",
                $time, what, got, exp));
        end
    endtask

    task automatic check_latency(input int got, input int exp);
        if (got != exp) begin
            stop_run($sformatf("mismatch at time %0t: load took %0d edges, expected %0d",
                $time, got, exp));
        end
    endtask

    task automatic add_row(input logic st, input mem_size_e sz, input logic sg,
                           input logic [11:0] off, input word_t base, input logic [1:0] late,
                           input logic [1:0] port, input logic [3:0] dly,
                           input logic [5:0] fl);
        tbl.push_back('{st, sz, sg, off, base, late, port, dly, fl});
    endtask

    // reference memory, applied in dispatch order
    task automatic model_access(input row_t r, input word_t sdata, input rob_id_t id);
        word_t       addr;
        logic        mis;
        int          idx;
        word_t       val;
        lsu_result_t e;
        addr = r.base + {{20{r.offset[11]}}, r.offset};
        mis  = (r.msize == MSIZE_HALF && addr[0]) ||
               (r.msize == MSIZE_WORD && addr[1:0] != 2'b00);
        idx  = (addr >> 2) % `LSU_MEM_WORDS;
        if (r.is_store) begin
            if (!mis) begin
                case (r.msize)
                    MSIZE_BYTE: ref_mem[idx][8*addr[1:0] +: 8] = sdata[7:0];
                    MSIZE_HALF: ref_mem[idx][16*addr[1] +: 16] = sdata[15:0];
                    default:    ref_mem[idx] = sdata;
                endcase
            end
        end else begin
            case (r.msize)
                MSIZE_BYTE: begin
                    val = ref_mem[idx][8*addr[1:0] +: 8];
                    if (r.msigned && val[7]) val[31:8] = '1;
                end
                MSIZE_HALF: begin
                    val = ref_mem[idx][16*addr[1] +: 16];
                    if (r.msigned && val[15]) val[31:16] = '1;
                end
                default: val = ref_mem[idx];
            endcase
            e.valid   = 1'b1;
            e.wreg_id = id;
            e.data    = mis ? '0 : val;
            e.ale     = mis;
            exp_q.push_back(e);
        end
    endtask

    // ------------------------------------------------------------------------
    // cycle stepping and dispatch
    // ------------------------------------------------------------------------
    task automatic drive_cdb();
        bcast_t keep [$];
        bcast_t b;
        while (sched.size() > 0) begin
            b = sched.pop_front();
            // one broadcast per port, a busy port pushes it to a later cycle
            if (b.cyc <= cyc && !cdb[b.port].valid) begin
                cdb[b.port].valid = 1'b1;
                cdb[b.port].id    = b.tag;
                cdb[b.port].data  = b.data;
            end else begin
                keep.push_back(b);
            end
        end
        sched = keep;
    endtask

    task automatic next_cycle();
        @(negedge clk);
        cyc++;
        if (result.valid) begin
            if (exp_q.size() == 0) begin
                stop_run($sformatf("unexpected load result for rob id %0d at time %0t",
                    result.wreg_id, $time));
            end else begin
                check_result(result, exp_q.pop_front());
                if (probe_on && result.wreg_id == probe_id) begin
                    check_latency(cyc - probe_cyc, 3);
                    probe_on = 1'b0;
                end
            end
        end
        disp = '0;
        cdb  = '0;
        drive_cdb();
    endtask

    task automatic idle(input int n);
        repeat (n) next_cycle();
    endtask

    task automatic wait_room();
        int n;
        n = 0;
        while (!entry_ready) begin
            if (n == 100) stop_run("entry_ready_o stayed low for 100 cycles");
            next_cycle();
            n++;
        end
    endtask

    task automatic drain(input int limit);
        int n;
        n = 0;
        while (exp_q.size() > 0 || sched.size() > 0) begin
            if (n == limit) begin
                stop_run($sformatf("result never arrived: %0d loads outstanding after %0d cycles",
                    exp_q.size(), limit));
            end
            next_cycle();
            n++;
        end
    endtask

    task automatic load_slot(input row_t r, output dispatch_t s);
        word_t  opnd [2];
        bcast_t b;
        opnd[0] = next_word();
        opnd[1] = r.base;
        wid = wid + rob_id_t'(1);
        s = '0;
        s.valid      = 1'b1;
        s.op.is_store = r.is_store;
        s.op.msize   = r.msize;
        s.op.msigned = r.msigned;
        s.op.offset  = r.offset;
        s.op.wreg_id = wid;
        for (int k = 0; k < 2; k++) begin
            if (r.late[k]) begin
                // tag 0 is never broadcast
                tag_ctr = (tag_ctr == '1) ? rob_id_t'(1) : tag_ctr + rob_id_t'(1);
                s.src_id[k] = tag_ctr;
                b.cyc  = cyc + int'(r.delay);
                b.port = r.port[k];
                b.tag  = tag_ctr;
                b.data = opnd[k];
                if (has(r, SQUASH)) held.push_back(b);
                else sched.push_back(b);
            end else begin
                s.src_ready[k] = 1'b1;
                s.src_data[k]  = opnd[k];
            end
        end
        if (has(r, TIMED)) begin
            probe_on  = 1'b1;
            probe_id  = wid;
            probe_cyc = cyc;
        end
        if (!has(r, SQUASH)) model_access(r, opnd[0], wid);
    endtask

    task automatic dispatch_rows(input row_t r0, input row_t r1, input logic two);
        dispatch_t s0;
        dispatch_t s1;
        wait_room();
        load_slot(r0, s0);
        if (two) begin
            load_slot(r1, s1);
            disp[0] = s0;
            disp[1] = s1;
        end else if (has(r0, SLOT1)) begin
            disp[1] = s0;
        end else begin
            disp[0] = s0;
        end
        drive_cdb();
        next_cycle();
        if (has(two ? r1 : r0, RDY_LO)) begin
            check_ready(entry_ready, 1'b0, "with fewer than two entries free");
        end
    endtask

    task automatic flush_queue();
        drain(200);
        idle(6);
        flush = 1'b1;
        next_cycle();
        flush = 1'b0;
        check_ready(entry_ready, 1'b1, "after flush");
        // wake the squashed operands, nothing may come back
        foreach (held[k]) begin
            held[k].cyc = cyc + 1;
            sched.push_back(held[k]);
        end
        held = {};
    endtask

    // ------------------------------------------------------------------------
    // stimulus table
    // ------------------------------------------------------------------------
    task automatic build_table();
        // fill the whole scratchpad with word stores
        for (int i = 0; i < `LSU_MEM_WORDS; i++) begin
            add_row(1'b1, MSIZE_WORD, 1'b0, 12'h0, word_t'(4 * i), 2'b00, 2'b00, 4'd0, 6'd0);
        end
        // every lane of four words, both extensions
        for (int i = 0; i < 32; i++) begin
            add_row(1'b0, MSIZE_BYTE, i[0], 12'(i[2:1]), word_t'(32'h80 + 4 * i[4:3]),
                    2'b00, 2'b00, 4'd0, 6'd0);
        end
        for (int i = 0; i < 16; i++) begin
            add_row(1'b0, MSIZE_HALF, i[0], 12'({i[1], 1'b0}), word_t'(32'h80 + 4 * i[3:2]),
                    2'b00, 2'b00, 4'd0, 6'd0);
        end
        // sub-word stores read back, negative offset and address wrap
        add_row(1'b1, MSIZE_HALF, 1'b0, 12'hffe, 32'h104, 2'b00, 2'b00, 4'd0, 6'd0);
        add_row(1'b0, MSIZE_HALF, 1'b1, 12'h002, 32'h100, 2'b00, 2'b00, 4'd0, 6'd0);
        add_row(1'b1, MSIZE_BYTE, 1'b0, 12'h003, 32'h0c0, 2'b00, 2'b00, 4'd0, 6'd0);
        add_row(1'b0, MSIZE_BYTE, 1'b1, 12'h003, 32'h0c0, 2'b00, 2'b00, 4'd0, 6'd0);
        add_row(1'b0, MSIZE_WORD, 1'b0, 12'h000, 32'h0c0, 2'b00, 2'b00, 4'd0, 6'd0);
        // operands from the cdb, delay 0 is the dispatch cycle itself
        add_row(1'b1, MSIZE_WORD, 1'b0, 12'h000, 32'h020, 2'b01, 2'b00, 4'd0, 6'd0);
        add_row(1'b0, MSIZE_WORD, 1'b0, 12'h000, 32'h020, 2'b10, 2'b10, 4'd0, 6'd0);
        add_row(1'b0, MSIZE_HALF, 1'b0, 12'h002, 32'h024, 2'b11, 2'b01, 4'd5, 6'd0);
        add_row(1'b1, MSIZE_BYTE, 1'b0, 12'h001, 32'h024, 2'b11, 2'b10, 4'd3, 6'd0);
        add_row(1'b0, MSIZE_BYTE, 1'b1, 12'h001, 32'h024, 2'b10, 2'b00, 4'd1, 6'd0);
        // dual dispatch until the queue runs out of room
        add_row(1'b0, MSIZE_WORD, 1'b0, 12'h000, 32'h030, 2'b10, 2'b00, 4'd8, PAIR);
        add_row(1'b1, MSIZE_HALF, 1'b0, 12'h000, 32'h030, 2'b11, 2'b01, 4'd8, 6'd0);
        add_row(1'b0, MSIZE_HALF, 1'b1, 12'h000, 32'h030, 2'b10, 2'b10, 4'd9, PAIR);
        add_row(1'b0, MSIZE_WORD, 1'b0, 12'h000, 32'h030, 2'b00, 2'b00, 4'd0, RDY_LO);
        add_row(1'b0, MSIZE_BYTE, 1'b0, 12'h003, 32'h030, 2'b00, 2'b00, 4'd0, SLOT1);
        // misaligned accesses
        add_row(1'b0, MSIZE_HALF, 1'b1, 12'h001, 32'h040, 2'b00, 2'b00, 4'd0, 6'd0);
        add_row(1'b0, MSIZE_WORD, 1'b0, 12'h002, 32'h040, 2'b00, 2'b00, 4'd0, 6'd0);
        add_row(1'b1, MSIZE_WORD, 1'b0, 12'h001, 32'h040, 2'b00, 2'b00, 4'd0, 6'd0);
        add_row(1'b1, MSIZE_HALF, 1'b0, 12'h003, 32'h040, 2'b00, 2'b00, 4'd0, 6'd0);
        add_row(1'b0, MSIZE_WORD, 1'b0, 12'h000, 32'h040, 2'b00, 2'b00, 4'd0, 6'd0);
        // waiting operations thrown away by a flush
        add_row(1'b0, MSIZE_WORD, 1'b0, 12'h000, 32'h050, 2'b10, 2'b00, 4'd0, PAIR | SQUASH);
        add_row(1'b0, MSIZE_BYTE, 1'b0, 12'h000, 32'h050, 2'b01, 2'b00, 4'd0, SQUASH);
        add_row(1'b0, MSIZE_WORD, 1'b0, 12'h000, 32'h054, 2'b11, 2'b01, 4'd0, PAIR | SQUASH);
        add_row(1'b0, MSIZE_WORD, 1'b0, 12'h000, 32'h054, 2'b10, 2'b10, 4'd0,
                SQUASH | RDY_LO | FLUSH);
        add_row(1'b0, MSIZE_WORD, 1'b1, 12'h000, 32'h050, 2'b00, 2'b00, 4'd0, 6'd0);
        // fixed load latency on an idle queue
        add_row(1'b0, MSIZE_BYTE, 1'b1, 12'h002, 32'h050, 2'b00, 2'b00, 4'd0, TIMED);
    endtask

    // ------------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------------
    initial begin
        int   i;
        logic two;
        row_t last;
        rst      = 1'b1;
        flush    = 1'b0;
        disp     = '0;
        cdb      = '0;
        rng      = 32'd78558;
        tag_ctr  = '0;
        wid      = '0;
        cyc      = 0;
        probe_on = 1'b0;
        build_table();

        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_ready(entry_ready, 1'b1, "after reset");

        i = 0;
        while (i < tbl.size()) begin
            two = has(tbl[i], PAIR) && (i + 1 < tbl.size());
            if (has(tbl[i], TIMED)) begin
                drain(200);
                idle(4);
            end
            dispatch_rows(tbl[i], two ? tbl[i+1] : tbl[i], two);
            last = two ? tbl[i+1] : tbl[i];
            if (has(last, FLUSH)) flush_queue();
            i += two ? 2 : 1;
        end

        drain(400);
        idle(10);
        if (exp_q.size() == 0 && !probe_on) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            stop_run("the timed load never reported its result");
        end
    end

endmodule
